//--- logic/csi2_pkg.sv
`default_nettype none

package csi2_pkg;

    // ----------------------------------------
    // image geometry and packet fields
    // ----------------------------------------
    localparam int img_width  = 8;   // multiple of 8.
    localparam int img_height = 4;

    localparam logic [15:0] word_count = 16'(img_width * 10 / 8);

    localparam logic [7:0] dt_raw10       = 8'h2b;
    localparam logic [7:0] dt_frame_start = 8'h00;
    localparam logic [7:0] dt_frame_end   = 8'h01;

    localparam int fifo_depth  = 8;
    localparam int fifo_ptr_w  = $clog2(fifo_depth);
    localparam int fifo_cnt_w  = $clog2(fifo_depth + 1);
    localparam int line_cnt_w  = $clog2(img_height + 1);

    // ----------------------------------------
    // beat structs
    // ----------------------------------------
    typedef struct packed {
        logic [9:0] pixel;
        logic       sof;
    } pix_beat_t;

    typedef struct packed {
        logic [1:0][7:0] data;   // data[0] goes first.
        logic            sof;
    } byte_beat_t;

    // hamming parity over DI and WC, byte 0 in d[7:0].
    function automatic logic [7:0] csi2_ecc(input logic [23:0] d);
        logic [5:0] p;
        p[0] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[13]
             ^ d[16] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
        p[1] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[12] ^ d[14]
             ^ d[17] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
        p[2] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[11] ^ d[12] ^ d[15]
             ^ d[18] ^ d[20] ^ d[21] ^ d[22];
        p[3] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[13] ^ d[14] ^ d[15]
             ^ d[19] ^ d[20] ^ d[21] ^ d[23];
        p[4] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[16] ^ d[17] ^ d[18]
             ^ d[19] ^ d[20] ^ d[22] ^ d[23];
        p[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17]
             ^ d[18] ^ d[19] ^ d[21] ^ d[22] ^ d[23];
        return {2'b00, p};
    endfunction

    // x^16 + x^12 + x^5 + 1, reflected, lsb first.
    function automatic logic [15:0] csi2_crc16_byte(input logic [15:0] crc,
                                                    input logic [7:0]  data);
        logic [15:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ 16'h8408;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

`default_nettype wire

//--- logic/stream_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module stream_fifo #(
    parameter type payload_t = logic
) (
    input  var logic     dphy_clk,
    input  var logic     arst_n,

    input  var logic     in_valid,
    output var logic     in_ready,
    input  var payload_t in_data,

    output var logic     out_valid,
    input  var logic     out_ready,
    output var payload_t out_data
);

    import csi2_pkg::*;

    payload_t mem [fifo_depth];

    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_cnt_w-1:0] count;
    logic                  push;
    logic                  pop;

    assign in_ready  = (count != fifo_cnt_w'(fifo_depth));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge dphy_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge dphy_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- logic/raw10_packer.sv
`timescale 1ns/10ps
`default_nettype none

module raw10_packer (
    input  var logic                   dphy_clk,
    input  var logic                   arst_n,

    input  var logic                   in_valid,
    output var logic                   in_ready,
    input  var csi2_pkg::pix_beat_t    in_data,

    output var logic                   out_valid,
    input  var logic                   out_ready,
    output var csi2_pkg::byte_beat_t   out_data
);

    import csi2_pkg::*;

    // ----------------------------------------
    // pixel group being collected
    // ----------------------------------------
    logic [3:0][9:0] grp_pix;
    logic [2:0]      grp_cnt;   // 0..4.
    logic            grp_sof;
    logic            grp_full;
    logic [4:0][7:0] grp_bytes;

    // ----------------------------------------
    // group in flight
    // ----------------------------------------
    logic [4:0][7:0] hold;
    logic [2:0]      hold_idx;
    logic            hold_full;
    logic            hold_sof;

    logic pair_xfer;
    logic grp_take;

    assign grp_full = (grp_cnt == 3'd4);
    assign in_ready = !grp_full;

    // upper bits first, then the packed low bits.
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            grp_bytes[k] = grp_pix[k][9:2];
        end
        grp_bytes[4] = {grp_pix[3][1:0], grp_pix[2][1:0], grp_pix[1][1:0], grp_pix[0][1:0]};
    end

    // pair at index 4 borrows byte 0 of the next group.
    assign out_valid = hold_full && ((hold_idx != 3'd4) || grp_full);
    assign pair_xfer = out_valid && out_ready;
    assign grp_take  = grp_full && (!hold_full || (pair_xfer && hold_idx == 3'd4));

    always_comb begin
        out_data.sof     = hold_sof;
        out_data.data[0] = hold[hold_idx];
        if (hold_idx == 3'd4) begin
            out_data.data[1] = grp_bytes[0];
        end else begin
            out_data.data[1] = hold[hold_idx + 3'd1];
        end
    end

    always_ff @(posedge dphy_clk or negedge arst_n) begin
        if (!arst_n) begin
            grp_cnt   <= '0;
            hold_idx  <= '0;
            hold_full <= 1'b0;
            hold_sof  <= 1'b0;
        end else begin
            if (grp_take) begin
                grp_cnt <= '0;
            end else if (in_valid && in_ready) begin
                grp_cnt <= grp_cnt + 3'd1;
            end

            if (pair_xfer) begin
                hold_sof <= 1'b0;
                if (hold_idx == 3'd4) begin
                    hold_idx <= 3'd1;   // byte 0 of new group already sent.
                end else if (hold_idx == 3'd3) begin
                    hold_idx  <= '0;
                    hold_full <= 1'b0;
                end else begin
                    hold_idx <= hold_idx + 3'd2;
                end
            end else if (!hold_full && grp_full) begin
                hold_full <= 1'b1;
                hold_idx  <= '0;
                hold_sof  <= grp_sof;
            end
        end
    end

    always_ff @(posedge dphy_clk) begin
        if (in_valid && in_ready) begin
            grp_pix[grp_cnt[1:0]] <= in_data.pixel;
            if (grp_cnt == 3'd0) begin
                grp_sof <= in_data.sof;
            end
        end
        if (grp_take) begin
            hold <= grp_bytes;
        end
    end

endmodule

`default_nettype wire

//--- logic/csi2_packet_2lane.sv
`timescale 1ns/10ps
`default_nettype none

module csi2_packet_2lane (
    input  var logic                   dphy_clk,
    input  var logic                   arst_n,

    input  var logic                   in_valid,
    output var logic                   in_ready,
    input  var csi2_pkg::byte_beat_t   in_data,

    output var logic                   hs_valid,
    input  var logic                   hs_ready,
    output var logic [1:0][7:0]        hs_data
);

    import csi2_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_fs,
        st_hdr,
        st_pay,
        st_ftr,
        st_fe,
        st_gap
    } state_t;

    state_t state;
    state_t gap_next;

    logic                  pair_sel;   // second pair of a 4-byte header.
    logic [line_cnt_w-1:0] line_cnt;
    logic [15:0]           pay_left;
    logic [15:0]           crc;
    logic [15:0]           crc_next;
    logic [23:0]           cur_hdr;
    logic [7:0]            cur_ecc;
    logic                  hs_xfer;
    logic                  last_line;

    assign hs_xfer   = hs_valid && hs_ready;
    assign in_ready  = (state == st_pay) && hs_ready;
    assign last_line = (line_cnt == line_cnt_w'(img_height - 1));
    assign crc_next  = csi2_crc16_byte(csi2_crc16_byte(crc, in_data.data[0]), in_data.data[1]);

    // ----------------------------------------
    // header and output mux
    // ----------------------------------------
    always_comb begin
        case (state)
            st_fs:   cur_hdr = {16'h0000, dt_frame_start};
            st_fe:   cur_hdr = {16'h0000, dt_frame_end};
            default: cur_hdr = {word_count, dt_raw10};
        endcase
        cur_ecc = csi2_ecc(cur_hdr);
    end

    always_comb begin
        hs_valid = 1'b0;
        hs_data  = '0;
        case (state)
            st_fs, st_hdr, st_fe: begin
                hs_valid = 1'b1;
                if (pair_sel) begin
                    hs_data[0] = cur_hdr[23:16];
                    hs_data[1] = cur_ecc;
                end else begin
                    hs_data[0] = cur_hdr[7:0];
                    hs_data[1] = cur_hdr[15:8];
                end
            end
            st_pay: begin
                hs_valid = in_valid;   // an empty byte FIFO stalls the payload.
                hs_data  = in_data.data;
            end
            st_ftr: begin
                hs_valid   = 1'b1;
                hs_data[0] = crc[7:0];
                hs_data[1] = crc[15:8];
            end
            default: begin
                hs_valid = 1'b0;
            end
        endcase
    end

    // ----------------------------------------
    // packet sequencing
    // ----------------------------------------
    always_ff @(posedge dphy_clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            gap_next <= st_idle;
            pair_sel <= 1'b0;
            line_cnt <= '0;
            pay_left <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (in_valid) begin
                        pair_sel <= 1'b0;
                        if (in_data.sof) begin
                            line_cnt <= '0;
                            state    <= st_fs;
                        end else begin
                            state <= st_hdr;
                        end
                    end
                end
                st_fs, st_fe: begin
                    if (hs_xfer) begin
                        pair_sel <= !pair_sel;
                        if (pair_sel) begin
                            gap_next <= (state == st_fs) ? st_hdr : st_idle;
                            state    <= st_gap;
                        end
                    end
                end
                st_hdr: begin
                    if (hs_xfer) begin
                        pair_sel <= !pair_sel;
                        if (pair_sel) begin
                            pay_left <= word_count;
                            state    <= st_pay;
                        end
                    end
                end
                st_pay: begin
                    if (hs_xfer) begin
                        pay_left <= pay_left - 16'd2;
                        if (pay_left == 16'd2) begin
                            state <= st_ftr;
                        end
                    end
                end
                st_ftr: begin
                    if (hs_xfer) begin
                        line_cnt <= line_cnt + 1'b1;
                        gap_next <= last_line ? st_fe : st_idle;
                        state    <= st_gap;
                    end
                end
                default: begin
                    state <= gap_next;   // one idle cycle between bursts.
                end
            endcase
        end
    end

    // seeded during the header, covers payload only.
    always_ff @(posedge dphy_clk) begin
        if (state == st_hdr) begin
            crc <= 16'hffff;
        end else if (state == st_pay && hs_xfer) begin
            crc <= crc_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/csi2_tx_top.sv
`timescale 1ns/10ps
`default_nettype none

module csi2_tx_top (
    input  var logic                  dphy_clk,
    input  var logic                  arst_n,

    input  var logic                  pix_valid,
    output var logic                  pix_ready,
    input  var csi2_pkg::pix_beat_t   pix_beat,

    output var logic                  hs_valid,
    input  var logic                  hs_ready,
    output var logic [1:0][7:0]       hs_data
);

    import csi2_pkg::*;

    // ----------------------------------------
    // internal links
    // ----------------------------------------
    logic       pix_q_valid;
    logic       pix_q_ready;
    pix_beat_t  pix_q_beat;

    logic       pk_valid;
    logic       pk_ready;
    byte_beat_t pk_beat;

    logic       byte_q_valid;
    logic       byte_q_ready;
    byte_beat_t byte_q_beat;

    stream_fifo #(
        .payload_t (pix_beat_t)
    ) u_pix_fifo (
        .dphy_clk  (dphy_clk),
        .arst_n    (arst_n),
        .in_valid  (pix_valid),
        .in_ready  (pix_ready),
        .in_data   (pix_beat),
        .out_valid (pix_q_valid),
        .out_ready (pix_q_ready),
        .out_data  (pix_q_beat)
    );

    raw10_packer u_packer (
        .dphy_clk  (dphy_clk),
        .arst_n    (arst_n),
        .in_valid  (pix_q_valid),
        .in_ready  (pix_q_ready),
        .in_data   (pix_q_beat),
        .out_valid (pk_valid),
        .out_ready (pk_ready),
        .out_data  (pk_beat)
    );

    // absorbs packer output while the framer sends headers.
    stream_fifo #(
        .payload_t (byte_beat_t)
    ) u_byte_fifo (
        .dphy_clk  (dphy_clk),
        .arst_n    (arst_n),
        .in_valid  (pk_valid),
        .in_ready  (pk_ready),
        .in_data   (pk_beat),
        .out_valid (byte_q_valid),
        .out_ready (byte_q_ready),
        .out_data  (byte_q_beat)
    );

    csi2_packet_2lane u_framer (
        .dphy_clk  (dphy_clk),
        .arst_n    (arst_n),
        .in_valid  (byte_q_valid),
        .in_ready  (byte_q_ready),
        .in_data   (byte_q_beat),
        .hs_valid  (hs_valid),
        .hs_ready  (hs_ready),
        .hs_data   (hs_data)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output var logic dphy_clk,
    output var logic arst_n
);

    initial begin
        dphy_clk = 1'b0;
        forever #5 dphy_clk = ~dphy_clk;   // 10 ns period.
    end

    initial begin
        arst_n = 1'b0;
        repeat (16) @(posedge dphy_clk);
        #1 arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/csi2_tx_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module csi2_tx_asserts (
    input var logic        dphy_clk,
    input var logic        arst_n,
    input var logic        in_valid,
    input var logic        in_ready,
    input var logic        pay_state,
    input var logic        hs_valid,
    input var logic        hs_ready,
    input var logic [15:0] hs_data
);

    int fail_count = 0;

    // a stalled pair holds until the PHY takes it.
    stall_hold: assert property (
        @(posedge dphy_clk) disable iff (!arst_n)
        hs_valid && !hs_ready |=> hs_valid && $stable(hs_data)
    ) else begin
        $error("hs_valid or hs_data changed while stalled");
        fail_count++;
    end

    reset_idle: assert property (
        @(posedge dphy_clk) !arst_n |-> !hs_valid
    ) else begin
        $error("hs_valid high during reset");
        fail_count++;
    end

    // a pair taken from the byte FIFO leaves on the wire in the same cycle.
    ready_in_payload: assert property (
        @(posedge dphy_clk) disable iff (!arst_n)
        in_valid && in_ready |-> pay_state && hs_valid && hs_ready
    ) else begin
        $error("in_ready high outside a payload transfer");
        fail_count++;
    end

endmodule

bind csi2_packet_2lane csi2_tx_asserts u_asserts (
    .dphy_clk  (dphy_clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .pay_state (state == st_pay),
    .hs_valid  (hs_valid),
    .hs_ready  (hs_ready),
    .hs_data   (hs_data)
);

`default_nettype wire

//--- testbench/tb_csi2_tx.sv
`timescale 1ns/10ps
`default_nettype none

module tb_csi2_tx;

    import csi2_pkg::*;

    localparam int          n_frames      = 3;
    localparam int          pix_per_frame = img_width * img_height;
    localparam logic [15:0] line_bytes    = 16'(img_width / 4 * 5);   // five bytes per group.

    // syndrome column of each header bit, d23 first.
    localparam logic [23:0][5:0] ecc_cols = {
        6'h3b, 6'h37, 6'h2f, 6'h1f, 6'h38, 6'h34, 6'h32, 6'h31,
        6'h2c, 6'h2a, 6'h29, 6'h26, 6'h25, 6'h23, 6'h1c, 6'h1a,
        6'h19, 6'h16, 6'h15, 6'h13, 6'h0e, 6'h0d, 6'h0b, 6'h07
    };

    logic            dphy_clk;
    logic            arst_n;
    logic            pix_valid;
    logic            pix_ready;
    pix_beat_t       pix_beat;
    logic            hs_valid;
    logic            hs_ready;
    logic [1:0][7:0] hs_data;

    integer      seed;
    logic [9:0]  pix_q[$];
    logic [7:0]  burst_bytes[$];
    logic [16:0] exp_q[$];   // bit 16 marks the last pair of a burst.
    logic [15:0] line_crc;
    int          total_pairs;
    int          total_bursts;
    int          pairs_seen;
    int          bursts_seen;
    int          value_errors;
    int          other_errors;

    tb_clock_gen u_clock_gen (
        .dphy_clk (dphy_clk),
        .arst_n   (arst_n)
    );

    csi2_tx_top u_csi2_tx_top (
        .dphy_clk  (dphy_clk),
        .arst_n    (arst_n),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix_beat  (pix_beat),
        .hs_valid  (hs_valid),
        .hs_ready  (hs_ready),
        .hs_data   (hs_data)
    );

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic logic [7:0] header_ecc(input logic [23:0] hdr);
        logic [5:0] p;
        p = '0;
        for (int j = 0; j < 24; j++) begin
            if (hdr[j]) begin
                p = p ^ ecc_cols[j];
            end
        end
        return {2'b00, p};
    endfunction

    function automatic logic [15:0] crc_update(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb    = c[0] ^ b[i];
            c     = {fb, c[15:1]};
            c[10] = c[10] ^ fb;   // x^5 tap, reflected.
            c[3]  = c[3] ^ fb;    // x^12 tap, reflected.
        end
        return c;
    endfunction

    task automatic add_header(input logic [7:0] di, input logic [15:0] wc);
        logic [23:0] hdr;
        hdr = {wc, di};
        burst_bytes.push_back(hdr[7:0]);
        burst_bytes.push_back(hdr[15:8]);
        burst_bytes.push_back(hdr[23:16]);
        burst_bytes.push_back(header_ecc(hdr));
    endtask

    task automatic add_payload_byte(input logic [7:0] b);
        burst_bytes.push_back(b);
        line_crc = crc_update(line_crc, b);
    endtask

    task automatic close_burst();
        int   n;
        logic last;
        n = burst_bytes.size();
        for (int i = 0; i < n; i += 2) begin
            last = (i + 2 == n);
            exp_q.push_back({last, burst_bytes[i + 1], burst_bytes[i]});
        end
        total_pairs  += n / 2;
        total_bursts += 1;
        burst_bytes.delete();
    endtask

    task automatic build_model();
        logic [3:0][9:0] grp;
        int              n;
        n = 0;
        for (int i = 0; i < n_frames * pix_per_frame; i++) begin
            pix_q.push_back(10'($random(seed)));
        end
        for (int f = 0; f < n_frames; f++) begin
            add_header(8'h00, 16'h0000);
            close_burst();
            for (int l = 0; l < img_height; l++) begin
                add_header(8'h2b, line_bytes);
                line_crc = 16'hffff;
                for (int g = 0; g < img_width / 4; g++) begin
                    for (int k = 0; k < 4; k++) begin
                        grp[k] = pix_q[n];
                        n++;
                    end
                    for (int k = 0; k < 4; k++) begin
                        add_payload_byte(grp[k][9:2]);
                    end
                    add_payload_byte({grp[3][1:0], grp[2][1:0], grp[1][1:0], grp[0][1:0]});
                end
                burst_bytes.push_back(line_crc[7:0]);
                burst_bytes.push_back(line_crc[15:8]);
                close_burst();
            end
            add_header(8'h01, 16'h0000);
            close_burst();
        end
    endtask

    // ----------------------------------------
    // checks and reporting
    // ----------------------------------------
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            value_errors++;
            $display("Fail %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic report_and_finish();
        int assert_errors;
        assert_errors = u_csi2_tx_top.u_framer.u_asserts.fail_count;
        $display("errors: %0d value, %0d other, %0d assertion; pairs %0d/%0d, bursts %0d/%0d",
                 value_errors, other_errors, assert_errors, pairs_seen, total_pairs,
                 bursts_seen, total_bursts);
        if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    task automatic watch_timeout();
        int cycles;
        int limit;
        cycles = 0;
        limit  = 40 * total_pairs + 2000;
        while (cycles < limit) begin
            @(posedge dphy_clk);
            cycles++;
        end
        other_errors++;
        $display("timeout after %0d cycles with %0d of %0d pairs received",
                 limit, pairs_seen, total_pairs);
        report_and_finish();
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    task automatic drive_pixels();
        int   n;
        logic took;
        n = 0;
        while (n < n_frames * pix_per_frame) begin
            @(posedge dphy_clk);
            took = pix_valid && pix_ready;
            #1;
            if (took) begin
                n++;
                pix_valid = 1'b0;
            end
            if (!pix_valid && n < n_frames * pix_per_frame && ($random(seed) & 3) != 0) begin
                pix_valid      = 1'b1;
                pix_beat.pixel = pix_q[n];
                pix_beat.sof   = (n % pix_per_frame == 0);
            end
        end
    endtask

    initial begin : phy_ready_model
        int   stall;
        logic prev_valid;
        stall      = 0;
        prev_valid = 1'b0;
        @(posedge arst_n);
        forever begin
            @(posedge dphy_clk);
            #1;
            if (hs_valid && !prev_valid) begin
                stall = $unsigned($random(seed)) % 12;
            end
            prev_valid = hs_valid;
            if (stall > 0) begin
                hs_ready = 1'b0;
                stall--;
            end else begin
                hs_ready = (($random(seed) & 3) != 0);   // high about 3 of 4 cycles.
            end
        end
    end

    initial begin : output_monitor
        logic [16:0] exp;
        logic        gap_due;
        gap_due = 1'b0;
        forever begin
            @(posedge dphy_clk);
            if (gap_due) begin
                check_value("hs_valid", hs_valid, 32'h0);
                if (!hs_valid) begin
                    bursts_seen++;   // burst closed by a low cycle.
                end
                gap_due = 1'b0;
            end
            if (hs_valid && hs_ready) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("extra pair %h on hs_data after the last expected burst", hs_data);
                end else begin
                    exp = exp_q.pop_front();
                    check_value("hs_data", hs_data, exp[15:0]);
                    pairs_seen++;
                    if (exp[16]) begin
                        gap_due = 1'b1;
                    end
                end
            end
        end
    end

    initial begin
        pix_valid    = 1'b0;
        pix_beat     = '0;
        hs_ready     = 1'b0;
        seed         = 32'hb33b_bdcd;
        total_pairs  = 0;
        total_bursts = 0;
        pairs_seen   = 0;
        bursts_seen  = 0;
        value_errors = 0;
        other_errors = 0;
        build_model();
        @(posedge arst_n);
        check_value("pix_ready", pix_ready, 32'h1);
        check_value("hs_valid", hs_valid, 32'h0);
        fork
            drive_pixels();
            watch_timeout();
        join_none
        wait (pairs_seen == total_pairs);
        repeat (20) @(posedge dphy_clk);   // window for stray pairs.
        check_value("burst count", bursts_seen, total_bursts);
        report_and_finish();
    end

endmodule

`default_nettype wire

//--- src.f
logic/csi2_pkg.sv
logic/stream_fifo.sv
logic/raw10_packer.sv
logic/csi2_packet_2lane.sv
logic/csi2_tx_top.sv
testbench/tb_clock_gen.sv
testbench/csi2_tx_asserts.sv
testbench/tb_csi2_tx.sv

//--- Bender.yml
package:
  name: csi2_tx

sources:
  - files:
      - logic/csi2_pkg.sv
      - logic/stream_fifo.sv
      - logic/raw10_packer.sv
      - logic/csi2_packet_2lane.sv
      - logic/csi2_tx_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/csi2_tx_asserts.sv
      - testbench/tb_csi2_tx.sv
